//--- verilog/aesPkg.sv
package aesPkg;

	localparam int blockWidth = 128;
	localparam int keyWidth = 256;
	localparam int numRounds = 14;
	localparam int numRoundKeys = 15;

	typedef logic [blockWidth-1:0] block_t;
	typedef logic [keyWidth-1:0] key_t;
	typedef logic [3:0] roundIdx_t;
	typedef logic [4:0] keyCount_t;

	//////////////////////////////////////////////////
	// Forward S-box
	//////////////////////////////////////////////////

	localparam logic [7:0] sBox [256] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	//////////////////////////////////////////////////
	// Byte and word helpers
	//////////////////////////////////////////////////

	function automatic logic [7:0] subByte(input logic [7:0] b);
		return sBox[b];
	endfunction

	function automatic logic [31:0] subWord(input logic [31:0] w);
		return {subByte(w[31:24]), subByte(w[23:16]), subByte(w[15:8]), subByte(w[7:0])};
	endfunction

	// Left rotate by one byte, a0 a1 a2 a3 becomes a1 a2 a3 a0
	function automatic logic [31:0] rotWord(input logic [31:0] w);
		return {w[23:0], w[31:24]};
	endfunction

	function automatic logic [7:0] xtime(input logic [7:0] b);
		logic [7:0] shifted;
		shifted = {b[6:0], 1'b0};
		if (b[7]) begin
			shifted = shifted ^ 8'h1b;
		end
		return shifted;
	endfunction

	// Only 1 to 7 are needed for a 256-bit key
	function automatic logic [31:0] rcon(input logic [2:0] idx);
		logic [7:0] rc;
		rc = 8'h01 << (idx - 3'd1);
		return {rc, 24'h000000};
	endfunction

endpackage

//--- verilog/aesKeySchedule.sv
module aesKeySchedule (
	input logic clk,
	input logic rstN,
	input logic start,
	input aesPkg::key_t key,
	output logic keyWe,
	output aesPkg::roundIdx_t keyIdx,
	output aesPkg::block_t roundKey
);
	import aesPkg::*;

	logic busy;
	roundIdx_t idx;
	// The two most recent round keys, k-2 and k-1
	block_t prevKey;
	block_t lastKey;

	logic [31:0] temp;
	logic [31:0] w0;
	logic [31:0] w1;
	logic [31:0] w2;
	logic [31:0] w3;
	block_t derivedKey;
	logic lastIdx;

	assign lastIdx = (idx == roundIdx_t'(numRoundKeys - 1));

	//////////////////////////////////////////////////
	// Next round key
	//////////////////////////////////////////////////

	always_comb begin
		if (idx[0]) begin
			temp = subWord(lastKey[31:0]);
		end else begin
			temp = subWord(rotWord(lastKey[31:0])) ^ rcon(idx[3:1]);
		end
		// Words chain within one key
		w0 = prevKey[127:96] ^ temp;
		w1 = prevKey[95:64] ^ w0;
		w2 = prevKey[63:32] ^ w1;
		w3 = prevKey[31:0] ^ w2;
		derivedKey = {w0, w1, w2, w3};
	end

	//////////////////////////////////////////////////
	// Write port towards the store
	//////////////////////////////////////////////////

	// Key 0 goes out in the start cycle itself
	assign keyWe = start | busy;
	assign keyIdx = start ? roundIdx_t'(0) : idx;

	always_comb begin
		if (start) begin
			roundKey = key[keyWidth-1 -: blockWidth];
		end else if (idx == roundIdx_t'(1)) begin
			roundKey = lastKey;
		end else begin
			roundKey = derivedKey;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			busy <= 1'b0;
			idx <= '0;
		end else if (start) begin
			busy <= 1'b1;
			idx <= roundIdx_t'(1);
		end else if (busy) begin
			if (lastIdx) begin
				busy <= 1'b0;
				idx <= '0;
			end else begin
				idx <= idx + roundIdx_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			prevKey <= key[keyWidth-1 -: blockWidth];
			lastKey <= key[blockWidth-1:0];
		end else if (busy && idx >= roundIdx_t'(2)) begin
			prevKey <= lastKey;
			lastKey <= derivedKey;
		end
	end

endmodule

//--- verilog/roundKeyStore.sv
module roundKeyStore (
	input logic clk,
	input logic rstN,
	input logic start,
	input logic keyWe,
	input aesPkg::roundIdx_t keyIdx,
	input aesPkg::block_t roundKey,
	input aesPkg::roundIdx_t readIdx,
	output aesPkg::block_t readKey,
	output aesPkg::keyCount_t keyCount
);
	import aesPkg::*;

	block_t keyMem [numRoundKeys];

	always_ff @(posedge clk) begin
		if (keyWe) begin
			keyMem[keyIdx] <= roundKey;
		end
	end

	assign readKey = keyMem[readIdx];

	// Start and the write of key 0 land on the same edge
	always_ff @(posedge clk) begin
		if (!rstN) begin
			keyCount <= '0;
		end else if (start) begin
			keyCount <= keyCount_t'(keyWe);
		end else if (keyWe) begin
			keyCount <= keyCount + keyCount_t'(1);
		end
	end

endmodule

//--- verilog/aesCipherCore.sv
module aesCipherCore (
	input logic clk,
	input logic rstN,
	input logic start,
	input aesPkg::block_t plaintext,
	input aesPkg::keyCount_t keyCount,
	output aesPkg::roundIdx_t readIdx,
	input aesPkg::block_t readKey,
	output logic done,
	output aesPkg::block_t result
);
	import aesPkg::*;

	logic busy;
	roundIdx_t round;
	block_t state;

	logic advance;
	logic lastRound;
	block_t substituted;
	block_t nextState;

	//////////////////////////////////////////////////
	// Round transforms
	//////////////////////////////////////////////////

	function automatic block_t subBytes(input block_t s);
		block_t r;
		for (int i = 0; i < 16; i++) begin
			r[8*i +: 8] = subByte(s[8*i +: 8]);
		end
		return r;
	endfunction

	// Byte n sits at bits 127-8n, column major, row r of column c is byte 4c+r
	function automatic block_t shiftRows(input block_t s);
		block_t r;
		int src;
		for (int c = 0; c < 4; c++) begin
			for (int row = 0; row < 4; row++) begin
				src = 4 * ((c + row) % 4) + row;
				r[127 - 8 * (4 * c + row) -: 8] = s[127 - 8 * src -: 8];
			end
		end
		return r;
	endfunction

	function automatic logic [31:0] mixColumn(input logic [31:0] w);
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		a0 = w[31:24];
		a1 = w[23:16];
		a2 = w[15:8];
		a3 = w[7:0];
		// 3x is xtime(x) ^ x
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	function automatic block_t mixColumns(input block_t s);
		block_t r;
		for (int c = 0; c < 4; c++) begin
			r[127 - 32 * c -: 32] = mixColumn(s[127 - 32 * c -: 32]);
		end
		return r;
	endfunction

	//////////////////////////////////////////////////
	// Round sequencing
	//////////////////////////////////////////////////

	// Wait until the producer has stored the key for this round
	assign advance = busy && (keyCount > keyCount_t'(round));
	assign lastRound = (round == roundIdx_t'(numRounds));
	assign readIdx = round;

	always_comb begin
		substituted = shiftRows(subBytes(state));
		if (round == roundIdx_t'(0)) begin
			nextState = plaintext ^ readKey;
		end else if (lastRound) begin
			nextState = substituted ^ readKey;
		end else begin
			nextState = mixColumns(substituted) ^ readKey;
		end
	end

	assign done = advance && lastRound;
	assign result = nextState;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			busy <= 1'b0;
			round <= '0;
		end else if (start) begin
			busy <= 1'b1;
			round <= '0;
		end else if (advance) begin
			if (lastRound) begin
				busy <= 1'b0;
				round <= '0;
			end else begin
				round <= round + roundIdx_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			state <= nextState;
		end
	end

endmodule

//--- verilog/aesEncryptTop.sv
module aesEncryptTop (
	input logic clk,
	input logic rstN,
	input logic req,
	input aesPkg::key_t key,
	input aesPkg::block_t plaintext,
	output logic ack,
	output aesPkg::block_t ciphertext
);
	import aesPkg::*;

	typedef enum logic [1:0] {stIdle, stBusy, stAcked} ctrlState_t;

	ctrlState_t ctrlState;
	logic start;
	logic done;
	block_t result;

	logic keyWe;
	roundIdx_t keyIdx;
	block_t roundKey;
	roundIdx_t readIdx;
	block_t readKey;
	keyCount_t keyCount;

	//////////////////////////////////////////////////
	// Four-phase handshake
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ctrlState <= stIdle;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			case (ctrlState)
				stIdle: begin
					if (req) begin
						start <= 1'b1;
						ctrlState <= stBusy;
					end
				end
				stBusy: begin
					if (done) begin
						ctrlState <= stAcked;
					end
				end
				// Held here until the requester lets go
				stAcked: begin
					if (!req) begin
						ctrlState <= stIdle;
					end
				end
				default: ctrlState <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			ciphertext <= result;
		end
	end

	assign ack = (ctrlState == stAcked);

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////

	aesKeySchedule keySchedule (
		.clk(clk), .rstN(rstN), .start(start), .key(key),
		.keyWe(keyWe), .keyIdx(keyIdx), .roundKey(roundKey)
	);

	roundKeyStore keyStore (
		.clk(clk), .rstN(rstN), .start(start),
		.keyWe(keyWe), .keyIdx(keyIdx), .roundKey(roundKey),
		.readIdx(readIdx), .readKey(readKey), .keyCount(keyCount)
	);

	aesCipherCore cipherCore (
		.clk(clk), .rstN(rstN), .start(start), .plaintext(plaintext),
		.keyCount(keyCount), .readIdx(readIdx), .readKey(readKey),
		.done(done), .result(result)
	);

endmodule

//--- tb/aesEncrypt_chk.sv
module aesEncryptChk (
	input logic clk,
	input logic rstN,
	input logic req,
	input logic ack,
	input aesPkg::block_t ciphertext
);

	// Read by the testbench at the end of the run
	int failCount = 0;

	//////////////////////////////////////////////////
	// Four-phase handshake
	//////////////////////////////////////////////////

	ackRiseWithReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(ack) |-> $past(req))
		else begin
			failCount++;
			$error("ack rose while req was low");
		end

	ackFallWithoutReq: assert property (@(posedge clk) disable iff (!rstN)
		$fell(ack) |-> !$past(req))
		else begin
			failCount++;
			$error("ack fell while req was still high");
		end

	// Result is frozen for as long as it is acknowledged
	cipherStable: assert property (@(posedge clk) disable iff (!rstN)
		ack && $past(ack) |-> $stable(ciphertext))
		else begin
			failCount++;
			$error("ciphertext changed while ack was high");
		end

endmodule

bind aesEncryptTop aesEncryptChk handshakeChk (
	.clk(clk), .rstN(rstN), .req(req), .ack(ack), .ciphertext(ciphertext)
);

//--- tb/aesEncryptTb.sv
module aesEncryptTb;
	import aesPkg::*;

	localparam int numVectors = 6;
	localparam int expectedLatency = 16;
	localparam int timeoutCycles = 40;

	typedef struct packed {
		key_t key;
		block_t plaintext;
		block_t expected;
		logic [7:0] hold;
		logic [7:0] resetAfter;
	} vector_t;

	logic clk;
	logic rstN;
	logic req;
	key_t key;
	block_t plaintext;
	logic ack;
	block_t ciphertext;

	vector_t vectors [numVectors];
	int seed;
	int errorCount;
	int checkCount;

	aesEncryptTop UUT (
		.clk(clk), .rstN(rstN), .req(req), .key(key), .plaintext(plaintext),
		.ack(ack), .ciphertext(ciphertext)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Vector table
	//////////////////////////////////////////////////

	task automatic loadVectors();
		key_t fipsKey;
		key_t nistKey;
		fipsKey = 256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
		nistKey = 256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4;
		// key, plaintext, ciphertext, req hold, reset after n cycles
		vectors[0] = '{fipsKey, 128'h00112233445566778899aabbccddeeff,
			128'h8ea2b7ca516745bfeafc49904b496089, 8'd2, 8'd0};
		vectors[1] = '{nistKey, 128'h6bc1bee22e409f96e93d7e117393172a,
			128'hf3eed1bdb5d2a03c064b5a7e3db181f8, 8'd0, 8'd0};
		// Aborted by reset, its ciphertext is never looked at
		vectors[2] = '{nistKey, 128'hae2d8a571e03ac9c9eb76fac45af8e51,
			128'h591ccb10d410ed26dc5ba74a31362870, 8'd0, 8'd7};
		vectors[3] = '{nistKey, 128'h30c81c46a35ce411e5fbc1191a0a52ef,
			128'hb6ed21b99ca6f4f9f153e7b1beafed1d, 8'd0, 8'd0};
		vectors[4] = '{nistKey, 128'hf69f2445df4f9b17ad2b417be66c3710,
			128'h23304b7a39f9f3ff067d8d8f9e24ecc7, 8'd0, 8'd0};
		vectors[5] = '{fipsKey, 128'h00112233445566778899aabbccddeeff,
			128'h8ea2b7ca516745bfeafc49904b496089, 8'd0, 8'd0};
		for (int i = 1; i < numVectors; i++) begin
			vectors[i].hold = 8'(1 + ($unsigned($random(seed)) % 5));
		end
	endtask

	//////////////////////////////////////////////////
	// Checks and waits
	//////////////////////////////////////////////////

	task automatic checkValue(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// Counts the falling edges that still show ack at the old level
	task automatic waitForAck(input logic level, output int cycles, output bit ok);
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < timeoutCycles) begin
			@(negedge clk);
			if (ack === level) begin
				ok = 1'b1;
			end else begin
				cycles++;
			end
		end
		if (!ok) begin
			errorCount++;
			$display("Timeout: ack did not go to %0b within %0d cycles", level, timeoutCycles);
		end
	endtask

	task automatic runVector(input vector_t v, output bit ok);
		int cycles;
		block_t held;
		ok = 1'b1;
		key = v.key;
		plaintext = v.plaintext;
		req = 1'b1;
		if (v.resetAfter != 8'd0) begin
			for (int i = 0; i < int'(v.resetAfter); i++) begin
				@(negedge clk);
				checkValue("ack", 128'(ack), 128'(1'b0));
			end
			rstN = 1'b0;
			req = 1'b0;
			for (int i = 0; i < 2; i++) begin
				@(negedge clk);
				checkValue("ack", 128'(ack), 128'(1'b0));
			end
			rstN = 1'b1;
			// Past the point where the aborted operation would have finished
			for (int i = 0; i < expectedLatency; i++) begin
				@(negedge clk);
				checkValue("ack", 128'(ack), 128'(1'b0));
			end
		end else begin
			waitForAck(1'b1, cycles, ok);
			if (ok) begin
				checkValue("latency", 128'(cycles), 128'(expectedLatency));
				checkValue("ciphertext", ciphertext, v.expected);
				held = ciphertext;
				// Requester keeps req high, the result must not move
				for (int h = 0; h < int'(v.hold); h++) begin
					@(negedge clk);
					checkValue("ack", 128'(ack), 128'(1'b1));
					checkValue("ciphertext", ciphertext, held);
				end
				req = 1'b0;
				waitForAck(1'b0, cycles, ok);
			end
		end
	endtask

	task automatic finishRun();
		int assertFails;
		assertFails = UUT.handshakeChk.failCount;
		errorCount += assertFails;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checkCount, errorCount, assertFails);
		if (errorCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		bit ok;
		rstN = 1'b0;
		req = 1'b0;
		key = '0;
		plaintext = '0;
		errorCount = 0;
		checkCount = 0;
		seed = 32'hb6b7;
		loadVectors();
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		// Idle with req low
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			checkValue("ack", 128'(ack), 128'(1'b0));
		end
		ok = 1'b1;
		for (int n = 0; n < numVectors && ok; n++) begin
			runVector(vectors[n], ok);
		end
		finishRun();
	end

endmodule

//--- project.f
verilog/aesPkg.sv
verilog/aesKeySchedule.sv
verilog/roundKeyStore.sv
verilog/aesCipherCore.sv
verilog/aesEncryptTop.sv
tb/aesEncrypt_chk.sv
tb/aesEncryptTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the AES-256 testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --top-module aesEncryptTb \
	-f project.f -Mdir "$buildDir" -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "Build failed with status $status"
	exit 1
fi

# Keep running past assertion errors so the testbench can report them
"./$buildDir/simv" +verilator+error+limit+1000 > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q -x -- '>>> PASS' "$logFile"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see $logFile"
exit 1
